/* demux_pkg.sv */
`default_nettype none

package demux_pkg;

   // width of one payload word on the stream
   localparam int DATA_W = 16;

   // number of output channels, kept a power of two so the tag covers it exactly
   localparam int NUM_CH = 4;

   // the tag selects one channel
   localparam int TAG_W = $clog2(NUM_CH);

   // words of storage per channel unless the top level says otherwise
   localparam int DEFAULT_ELS = 4;

   // one payload word
   typedef logic [DATA_W-1:0] data_t;

   // a channel number as carried next to each word
   typedef logic [TAG_W-1:0] tag_t;

   // one bit per channel, used for valids, readies and yumis
   typedef logic [NUM_CH-1:0] ch_mask_t;

endpackage

`default_nettype wire

/* tag_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module tag_dispatch
   (
      input  logic                clk_i,
      input  logic                rst_n_i,
      input  logic                v_i,
      input  demux_pkg::tag_t     tag_i,
      input  demux_pkg::ch_mask_t ready_i,
      output logic                yumi_o,
      output demux_pkg::ch_mask_t v_o
   );

   import demux_pkg::*;

   logic     active_r;
   ch_mask_t tag_hot;
   ch_mask_t grant;

   // the dispatcher stays idle until one clock edge has seen reset released
   // this keeps the first cycle after reset quiet even with v_i already high
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         active_r <= 1'b0;
      end
      else
      begin
         active_r <= 1'b1;
      end
   end

   // decode the tag into a one-hot channel mask
   always_comb
   begin
      tag_hot = '0;
      tag_hot[tag_i] = 1'b1;
   end

   // a word is taken only when its own channel has room,
   // so a full channel never blocks words for the others
   assign grant = tag_hot & ready_i & {NUM_CH{v_i & active_r}};

   // the grant doubles as the write strobe of the target FIFO
   assign v_o = grant;

   // at most one bit of grant is set
   assign yumi_o = |grant;

endmodule

`default_nettype wire

/* channel_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module channel_fifo
   #(
      parameter int els_p = demux_pkg::DEFAULT_ELS
   )
   (
      input  logic             clk_i,
      input  logic             rst_n_i,
      input  logic             v_i,
      input  demux_pkg::data_t data_i,
      output logic             ready_o,
      output logic             v_o,
      output demux_pkg::data_t data_o,
      input  logic             yumi_i
   );

   import demux_pkg::*;

   localparam int ptr_w_lp = $clog2(els_p);
   localparam int cnt_w_lp = $clog2(els_p + 1);

   data_t               mem [els_p];
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [cnt_w_lp-1:0] count_r;
   logic                wr_en;
   logic                rd_en;

   // pointers wrap at els_p, which need not be a power of two
   function automatic logic [ptr_w_lp-1:0] bump(input logic [ptr_w_lp-1:0] ptr);
      if (ptr == ptr_w_lp'(els_p - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign wr_en = v_i & ready_o;
   assign rd_en = yumi_i & v_o;

   // ready looks only at the count, so a full FIFO refuses a write
   // even in a cycle where the head is being removed
   assign ready_o = (count_r < cnt_w_lp'(els_p));
   assign v_o     = (count_r != '0);
   assign data_o  = mem[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         mem[wr_ptr_r] <= data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_r <= bump(wr_ptr_r);
         if (rd_en)
            rd_ptr_r <= bump(rd_ptr_r);
         // occupancy only moves when exactly one side is active
         case ({wr_en, rd_en})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

endmodule

`default_nettype wire

/* tagged_fifo_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module tagged_fifo_bank
   #(
      parameter int els_p = demux_pkg::DEFAULT_ELS
   )
   (
      input  logic                                     clk_i,
      input  logic                                     rst_n_i,
      input  logic                                     v_i,
      input  demux_pkg::tag_t                          tag_i,
      input  demux_pkg::data_t                         data_i,
      output logic                                     yumi_o,
      output demux_pkg::ch_mask_t                      v_o,
      input  demux_pkg::ch_mask_t                      yumi_i,
      output demux_pkg::data_t [demux_pkg::NUM_CH-1:0] data_o
   );

   import demux_pkg::*;

   // write strobes from the dispatcher and room flags back from the FIFOs
   ch_mask_t ch_v;
   ch_mask_t ch_ready;

   tag_dispatch i_dispatch
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (v_i),
         .tag_i   (tag_i),
         .ready_i (ch_ready),
         .yumi_o  (yumi_o),
         .v_o     (ch_v)
      );

   // every channel sees the same input word, only the strobed one stores it
   for (genvar i = 0; i < NUM_CH; i++)
   begin : g_ch
      channel_fifo
         #(
            .els_p (els_p)
         )
      i_fifo
         (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .v_i     (ch_v[i]),
            .data_i  (data_i),
            .ready_o (ch_ready[i]),
            .v_o     (v_o[i]),
            .data_o  (data_o[i]),
            .yumi_i  (yumi_i[i])
         );
   end

endmodule

`default_nettype wire

/* rr_merge.sv */
`timescale 1ns/100ps
`default_nettype none

module rr_merge
   (
      input  logic                                     clk_i,
      input  logic                                     rst_n_i,
      input  demux_pkg::ch_mask_t                      v_i,
      input  demux_pkg::data_t [demux_pkg::NUM_CH-1:0] data_i,
      output demux_pkg::ch_mask_t                      yumi_o,
      output logic                                     v_o,
      output demux_pkg::tag_t                          tag_o,
      output demux_pkg::data_t                         data_o,
      input  logic                                     yumi_i
   );

   import demux_pkg::*;

   tag_t last_r;
   tag_t held_r;
   logic hold_r;
   tag_t search_sel;
   tag_t sel;
   logic take;

   // first non-empty channel after the last grant, wrapping around
   always_comb
   begin
      int   idx;
      logic found;
      search_sel = last_r;
      found      = 1'b0;
      for (int k = 1; k <= NUM_CH; k++)
      begin
         idx = (int'(last_r) + k) % NUM_CH;
         if (!found && v_i[idx])
         begin
            search_sel = tag_t'(idx);
            found      = 1'b1;
         end
      end
   end

   // once a word is shown and not taken it stays selected,
   // otherwise a late arrival nearer in priority would steal the slot
   assign sel    = hold_r ? held_r : search_sel;
   assign v_o    = |v_i;
   assign tag_o  = sel;
   assign data_o = data_i[sel];
   assign take   = v_o & yumi_i;

   always_comb
   begin
      yumi_o      = '0;
      yumi_o[sel] = take;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         // channel 0 is the first one looked at after reset
         last_r <= tag_t'(NUM_CH - 1);
         hold_r <= 1'b0;
      end
      else if (take)
      begin
         last_r <= sel;
         hold_r <= 1'b0;
      end
      else if (v_o)
      begin
         hold_r <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (v_o)
      begin
         held_r <= sel;
      end
   end

endmodule

`default_nettype wire

/* tagged_demux_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tagged_demux_top
   #(
      parameter int els_p = demux_pkg::DEFAULT_ELS
   )
   (
      input  logic                clk_i,
      input  logic                rst_n_i,
      input  logic                in_v_i,
      input  demux_pkg::tag_t     in_tag_i,
      input  demux_pkg::data_t    in_data_i,
      output logic                in_yumi_o,
      output logic                out_v_o,
      output demux_pkg::tag_t     out_tag_o,
      output demux_pkg::data_t    out_data_o,
      input  logic                out_yumi_i
   );

   import demux_pkg::*;

   // per-channel streams between the buffer and the merger
   ch_mask_t                fifo_v;
   ch_mask_t                fifo_yumi;
   data_t [NUM_CH-1:0]      fifo_data;

   tagged_fifo_bank
      #(
         .els_p (els_p)
      )
   i_bank
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (in_v_i),
         .tag_i   (in_tag_i),
         .data_i  (in_data_i),
         .yumi_o  (in_yumi_o),
         .v_o     (fifo_v),
         .yumi_i  (fifo_yumi),
         .data_o  (fifo_data)
      );

   rr_merge i_merge
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (fifo_v),
         .data_i  (fifo_data),
         .yumi_o  (fifo_yumi),
         .v_o     (out_v_o),
         .tag_o   (out_tag_o),
         .data_o  (out_data_o),
         .yumi_i  (out_yumi_i)
      );

endmodule

`default_nettype wire

/* tagged_demux_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module rr_merge_sva
   (
      input logic                clk_i,
      input logic                rst_n_i,
      input demux_pkg::ch_mask_t v_i,
      input demux_pkg::ch_mask_t yumi_o,
      input logic                v_o,
      input demux_pkg::tag_t     tag_o,
      input demux_pkg::data_t    data_o,
      input logic                yumi_i
   );

   int fail_cnt = 0;

   // at most one channel is dequeued per cycle
   assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(yumi_o))
      else
      begin
         $error("merger yumi has more than one bit set");
         fail_cnt++;
      end

   assert property (@(posedge clk_i) disable iff (!rst_n_i) (yumi_o & ~v_i) == '0)
      else
      begin
         $error("merger yumi given to an empty channel");
         fail_cnt++;
      end

   // a word shown and not taken stays exactly as it was
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    v_o && !yumi_i |=> $stable(tag_o) && $stable(data_o))
      else
      begin
         $error("merger output changed while a word was waiting");
         fail_cnt++;
      end

endmodule

bind rr_merge rr_merge_sva i_sva (.*);

`default_nettype wire

/* tb_tagged_demux.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tagged_demux;

   import demux_pkg::*;

   localparam int ELS = DEFAULT_ELS;
   localparam int MAX_REC = 64;
   localparam int RESET_CYCLES = 8;

   logic  clk;
   logic  rst_n;
   logic  in_v;
   tag_t  in_tag;
   data_t in_data;
   logic  in_yumi;
   logic  out_v;
   tag_t  out_tag;
   data_t out_data;
   logic  out_yumi;

   // each record is kind, channel, flag and a 16-bit data field
   logic [27:0] trace_mem [MAX_REC];
   data_t       model_q [NUM_CH][$];
   int          drain_mode;
   tag_t        last_tag;
   logic        held;
   tag_t        held_tag;
   logic        seen_yumi;
   int          cycles;
   int          cycle_limit;
   int          test_num;
   logic        test_open;
   int          test_errs;
   int          total_errs;
   int          tests_passed;
   int          tests_failed;
   int          words_in;
   int          words_out;

   tagged_demux_top i_dut
      (
         .clk_i      (clk),
         .rst_n_i    (rst_n),
         .in_v_i     (in_v),
         .in_tag_i   (in_tag),
         .in_data_i  (in_data),
         .in_yumi_o  (in_yumi),
         .out_v_o    (out_v),
         .out_tag_o  (out_tag),
         .out_data_o (out_data),
         .out_yumi_i (out_yumi)
      );

   always #50 clk = ~clk;

   // cycles are counted from the release of reset to the end of the run
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         cycles++;
         if (cycles > cycle_limit)
         begin
            $display("timeout: no progress after %0d cycles in %s", cycles,
                     test_name(test_num));
            $display("** FAIL **");
            $finish;
         end
      end
   end

   function automatic string test_name(input int num);
      case (num)
         0:       return "reset";
         1:       return "integrity";
         2:       return "isolation";
         3:       return "round robin";
         4:       return "back-pressure";
         5:       return "completeness";
         default: return "unnamed";
      endcase
   endfunction

   function automatic int queued_words();
      int total;
      total = 0;
      for (int c = 0; c < NUM_CH; c++)
         total += model_q[c].size();
      return total;
   endfunction

   // walk down from the farthest channel so the nearest non-empty one wins
   function automatic tag_t next_channel();
      tag_t pick;
      int   idx;
      pick = last_tag;
      for (int k = NUM_CH; k >= 1; k--)
      begin
         idx = (int'(last_tag) + k) % NUM_CH;
         if (model_q[idx].size() > 0)
            pick = tag_t'(idx);
      end
      return pick;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("mismatch in %s: %s expected %0h, actual %0h", test_name(test_num), what,
               exp_val, act_val);
      test_errs++;
   endtask

   task automatic report_error(input string msg);
      $display("error in %s: %s", test_name(test_num), msg);
      test_errs++;
   endtask

   task automatic finish_test();
      if (test_open)
      begin
         if (test_errs == 0)
         begin
            $display("test %0d %s: passed", test_num, test_name(test_num));
            tests_passed++;
         end
         else
         begin
            $display("test %0d %s: failed with %0d errors", test_num, test_name(test_num),
                     test_errs);
            tests_failed++;
         end
         total_errs += test_errs;
      end
      test_open = 1'b0;
   endtask

   task automatic start_test(input int num);
      finish_test();
      test_num  = num;
      test_errs = 0;
      test_open = 1'b1;
   endtask

   task automatic check_quiet();
      if (in_yumi !== 1'b0)
         report_mismatch("in_yumi", 0, in_yumi);
      if (out_v !== 1'b0)
         report_mismatch("out_v", 0, out_v);
   endtask

   task automatic drive_drain();
      case (drain_mode)
         1:       out_yumi = out_v;
         2:       out_yumi = out_v && ($urandom() % 2 == 1);
         default: out_yumi = 1'b0;
      endcase
   endtask

   // runs at the falling edge, the model moves as the DUT will at the next rising edge
   task automatic check_cycle();
      tag_t exp_tag;
      logic exp_ready;
      exp_ready = model_q[in_tag].size() < ELS;
      if (out_v !== (queued_words() > 0))
         report_mismatch("out_v", queued_words() > 0, out_v);
      if (out_v === 1'b1 && queued_words() > 0)
      begin
         exp_tag = held ? held_tag : next_channel();
         if (out_tag !== exp_tag)
            report_mismatch("tag", exp_tag, out_tag);
         else if (out_data !== model_q[exp_tag][0])
            report_mismatch("data", model_q[exp_tag][0], out_data);
         if (out_yumi)
         begin
            void'(model_q[exp_tag].pop_front());
            last_tag = exp_tag;
            held     = 1'b0;
            words_out++;
         end
         else
         begin
            held     = 1'b1;
            held_tag = exp_tag;
         end
      end
      if (in_v && in_yumi !== exp_ready)
         report_mismatch("in_yumi", exp_ready, in_yumi);
      else if (!in_v && in_yumi !== 1'b0)
         report_error("in_yumi high without an input word");
      seen_yumi = (in_v === 1'b1 && in_yumi === 1'b1);
      if (seen_yumi)
      begin
         model_q[in_tag].push_back(in_data);
         words_in++;
      end
   endtask

   task automatic step();
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      #10;
      drive_drain();
   endtask

   // flag 0 expects a refusal, 1 an immediate accept, 2 holds the word until taken
   task automatic do_write(input tag_t ch, input int flag, input data_t data);
      in_v    = 1'b1;
      in_tag  = ch;
      in_data = data;
      step();
      if (flag < 2 && seen_yumi !== flag[0])
         report_mismatch("in_yumi from trace", flag, seen_yumi);
      while (flag == 2 && !seen_yumi)
         step();
      in_v = 1'b0;
   endtask

   initial
   begin
      logic [27:0] rec;
      int          n_rec;
      int          n_writes;
      int          n_idle;
      void'($urandom(32));
      clk          = 1'b0;
      rst_n        = 1'b0;
      in_v         = 1'b1;
      in_tag       = '0;
      in_data      = 16'h5a5a;
      out_yumi     = 1'b0;
      drain_mode   = 0;
      last_tag     = tag_t'(NUM_CH - 1);
      held         = 1'b0;
      cycles       = 0;
      test_open    = 1'b0;
      total_errs   = 0;
      tests_passed = 0;
      tests_failed = 0;
      words_in     = 0;
      words_out    = 0;
      for (int i = 0; i < MAX_REC; i++)
         trace_mem[i] = '0;
      $readmemh("demux_trace.txt", trace_mem);
      n_rec    = 0;
      n_writes = 0;
      n_idle   = 0;
      while (n_rec < MAX_REC && trace_mem[n_rec][27:24] != 4'h0)
      begin
         if (trace_mem[n_rec][27:24] == 4'h1)
            n_writes++;
         if (trace_mem[n_rec][27:24] == 4'h3)
            n_idle += int'(trace_mem[n_rec][15:0]);
         n_rec++;
      end
      cycle_limit = 2 * n_rec + 2 * n_writes + n_idle + 50;

      // the input word is offered all through reset and must not be taken
      start_test(0);
      if (n_rec == 0)
         report_error("trace file is empty or missing");
      repeat (RESET_CYCLES)
      begin
         @(negedge clk);
         check_quiet();
         @(posedge clk);
      end
      #10;
      rst_n = 1'b1;
      @(negedge clk);
      check_quiet();
      @(posedge clk);
      #10;
      in_v = 1'b0;

      for (int r = 0; r < n_rec; r++)
      begin
         rec = trace_mem[r];
         case (rec[27:24])
            4'h1: do_write(tag_t'(rec[23:20]), int'(rec[19:16]), rec[15:0]);
            4'h2:
            begin
               drain_mode = int'(rec[19:16]);
               drive_drain();
            end
            4'h3: repeat (rec[15:0]) step();
            4'h4: start_test(int'(rec[15:0]));
            default: report_error("unknown record kind in the trace");
         endcase
      end

      // final drain keeps a random drain random, an idle one is switched on
      start_test(5);
      if (drain_mode == 0)
         drain_mode = 1;
      drive_drain();
      while (queued_words() > 0)
         step();
      step();
      if (out_v !== 1'b0)
         report_error("out_v still high after the final drain");
      if (words_out != words_in)
         report_mismatch("word count", words_in, words_out);
      if (i_dut.i_merge.i_sva.fail_cnt != 0)
         report_error("merger assertions failed during the run");
      finish_test();
      $display("tests passed %0d, failed %0d, words in %0d, out %0d, errors %0d",
               tests_passed, tests_failed, words_in, words_out, total_errs);
      if (total_errs == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* demux_trace.txt */
// fields kind_chan_flag_data in hex: kind 1 write, 2 drain, 3 idle (data = cycles), 4 test start
// write flag 0 refused, 1 taken at once, 2 held until taken; drain flag 0 off, 1 on, 2 random
4_0_0_0001 // integrity and per-channel order
2_0_1_0000
1_0_1_a001
1_1_1_b001
1_0_1_a002
1_3_1_d001
1_2_1_c001
3_0_0_0005
4_0_0_0002 // a full channel blocks only itself
2_0_0_0000
1_1_1_1101
1_1_1_1102
1_1_1_1103
1_1_1_1104
1_1_0_1105
1_2_1_2201
2_0_1_0000
3_0_0_0006
4_0_0_0003 // round robin over filled channels
2_0_0_0000
1_2_1_3201
1_0_1_3001
1_3_1_3301
1_1_1_3101
1_2_1_3202
2_0_1_0000
3_0_0_0006
4_0_0_0004 // random output back-pressure
2_0_2_0000
1_3_2_4301
1_3_2_4302
1_1_2_4101
1_0_2_4001
1_2_2_4201
1_1_2_4102

/* build.f */
demux_pkg.sv
tag_dispatch.sv
channel_fifo.sv
tagged_fifo_bank.sv
rr_merge.sv
tagged_demux_top.sv
tagged_demux_sva.sv
tb_tagged_demux.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for the pass line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module tb_tagged_demux -Mdir "$build_dir" -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build_dir/tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$log_file"; then
   echo "simulation passed"
   exit 0
fi

echo "simulation failed"
exit 1
